//--- pll_cfg_pkg.sv
/*
 * clock synthesizer start-up configuration definitions
 * register map, configuration bus and divider width limits
 */
package pll_cfg_pkg;

    // divider field widths
    localparam int DIV_FIELD_W = 6;        // width of div_ratio on the cfg bus
    localparam int DIV_W_DEF   = 6;        // default counter width, top level may override
    localparam int DIV_MIN     = 2;        // smallest legal divide ratio
    localparam int EDGE_W      = 3;        // feedback edge target width

    // values loaded by RESET_N
    localparam int RST_DIV   = 4;
    localparam int RST_EDGES = 5;
    localparam bit RST_EXT   = 1'b1;       // external feedback after reset

    // register word addresses
    typedef enum logic [1:0] {
        CFG_DIV   = 2'd0,                  // divide ratio
        CFG_EDGES = 2'd1,                  // out0 rising edges to count
        CFG_CTRL  = 2'd2                   // bit 0: ext mode, write 1 to start
    } cfg_addr_e;

    // static configuration seen by sequencer and dividers
    typedef struct packed {
        logic [DIV_FIELD_W-1:0] div_ratio;  // period in FREF cycles, >= DIV_MIN
        logic [EDGE_W-1:0]      edge_target;
        logic                   ext_mode;   // 1 external, 0 post-divider feedback
    } pll_cfg_t;

endpackage

//--- pll_seq_pkg.sv
/*
 * start-up sequencer definitions
 * FSM states and the control bus toward the synthesizer
 */
package pll_seq_pkg;

    // sequencer states, 3 bit encoding
    typedef enum logic [2:0] {
        IDLE        = 3'd0,   // powerdown, bypass, dividers in reset
        REL_DIV     = 3'd1,   // release output dividers
        COUNT_EDGES = 3'd2,   // count feedback edges on out0
        WAIT_LOW    = 3'd3,   // wait for out0 low, then reset dividers
        RUN         = 3'd4    // normal operation
    } seq_state_e;

    // control outputs, all active high except the _n ones
    typedef struct packed {
        logic powerdown_n;    // 0 holds synthesizer in powerdown
        logic bypass_n;       // 0 bypasses the dividers
        logic out_en;         // 0 holds output dividers in reset
        logic seq_done;       // start-up finished
    } pll_ctrl_t;

endpackage

//--- pll_cfg_regs.sv
/*
 * configuration registers on a single-cycle strobe port
 * holds divide ratio, edge target and mode, issues the start pulse
 */
`timescale 1ns/10ps

module pll_cfg_regs #(
    parameter int DIV_W = pll_cfg_pkg::DIV_W_DEF
) (
    input  logic                   FREF,
    input  logic                   RESET_N,
    input  logic                   wr_stb,
    input  logic                   rd_stb,
    input  pll_cfg_pkg::cfg_addr_e addr,
    input  logic [7:0]             wdata,
    output logic [7:0]             rd_data,
    output pll_cfg_pkg::pll_cfg_t  cfg,
    output logic                   start
);
    import pll_cfg_pkg::*;

    logic [DIV_W-1:0]  div_q;    // divide ratio
    logic [EDGE_W-1:0] edges_q;  // edge target
    logic              ext_q;    // feedback mode
    logic [DIV_W-1:0]  wdiv;     // write data seen as a ratio

    assign wdiv = wdata[DIV_W-1:0];

    // register writes, take effect on the next FREF edge
    always_ff @(posedge FREF)
    begin
        if (!RESET_N)
        begin
            div_q   <= DIV_W'(RST_DIV);
            edges_q <= EDGE_W'(RST_EDGES);
            ext_q   <= RST_EXT;
            start   <= 1'b0;
        end
        else
        begin
            start <= 1'b0;  // one cycle pulse
            if (wr_stb)
            begin
                case (addr)
                    CFG_DIV:
                    begin
                        if (wdiv < DIV_W'(DIV_MIN))
                            div_q <= DIV_W'(DIV_MIN);  // clamp, counter needs 2+
                        else
                            div_q <= wdiv;
                    end
                    CFG_EDGES:
                        edges_q <= wdata[EDGE_W-1:0];
                    CFG_CTRL:
                    begin
                        ext_q <= wdata[0];
                        start <= wdata[0];  // write 1 launches the sequence
                    end
                    default:
                        ;  // unmapped, ignored
                endcase
            end
        end
    end

    // read-back, valid one cycle after rd_stb
    always_ff @(posedge FREF)
    begin
        if (rd_stb)
        begin
            case (addr)
                CFG_DIV:   rd_data <= 8'(div_q);
                CFG_EDGES: rd_data <= 8'(edges_q);
                CFG_CTRL:  rd_data <= {7'b0, ext_q};
                default:   rd_data <= 8'h00;
            endcase
        end
    end

    // pack the static configuration
    assign cfg.div_ratio   = DIV_FIELD_W'(div_q);
    assign cfg.edge_target = edges_q;
    assign cfg.ext_mode    = ext_q;

endmodule

//--- ext_fb_resync.sv
/*
 * feedback mode start-up sequencer
 * holds powerdown and bypass, counts out0 edges, resyncs the output dividers
 */
`timescale 1ns/10ps

module ext_fb_resync (
    input  logic                   FREF,
    input  logic                   RESET_N,
    input  logic                   start,
    input  logic                   out0,
    input  logic [2:0]             edge_target,
    output pll_seq_pkg::pll_ctrl_t ctrl
);
    import pll_seq_pkg::*;

    seq_state_e state;
    logic [2:0] edge_cnt;     // out0 rising edges seen
    logic       sync1;        // out0 synchronizer, first stage
    logic       sync2;        // second stage
    logic       sync2_d;      // previous sync2 for edge detect
    logic       out0_rise;

    assign out0_rise = sync2 & ~sync2_d;

    // out0 synchronizer
    // held clear while the dividers are in reset, so a restart
    // never sees a stale edge from the previous run
    always_ff @(posedge FREF)
    begin
        if (!RESET_N || !ctrl.out_en)
        begin
            sync1   <= 1'b0;
            sync2   <= 1'b0;
            sync2_d <= 1'b0;
        end
        else
        begin
            sync1   <= out0;
            sync2   <= sync1;
            sync2_d <= sync2;
        end
    end

    // FSM with registered outputs
    always_ff @(posedge FREF)
    begin
        if (!RESET_N)
        begin
            state    <= IDLE;
            ctrl     <= '0;
            edge_cnt <= '0;
        end
        else if (start)
        begin
            // restart from any state with IDLE outputs, leave next edge
            state    <= REL_DIV;
            ctrl     <= '0;
            edge_cnt <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    ctrl     <= '0;  // powerdown, bypass, dividers held
                    edge_cnt <= '0;
                end
                REL_DIV:
                begin
                    ctrl.out_en <= 1'b1;  // let dividers run
                    state       <= COUNT_EDGES;
                end
                COUNT_EDGES:
                begin
                    if (out0_rise && edge_cnt != 3'b111)
                        edge_cnt <= edge_cnt + 3'd1;  // saturating
                    if (edge_cnt >= edge_target && sync2)
                        state <= WAIT_LOW;
                end
                WAIT_LOW:
                begin
                    // raw out0 here, the divider is in this clock domain
                    // and a late view would cut a high phase short
                    if (!out0)
                    begin
                        ctrl.out_en <= 1'b0;  // divider reset pulse
                        state       <= RUN;
                    end
                end
                RUN:
                begin
                    ctrl.powerdown_n <= 1'b1;
                    ctrl.bypass_n    <= 1'b1;
                    ctrl.out_en      <= 1'b1;  // dividers restart aligned
                    ctrl.seq_done    <= 1'b1;
                end
                default:
                begin
                    state <= IDLE;
                    ctrl  <= '0;
                end
            endcase
        end
    end

endmodule

//--- out_div_bank.sv
/*
 * output divider bank, makes out0 and out1 from FREF
 * everything cleared while en is low
 */
`timescale 1ns/10ps

module out_div_bank #(
    parameter int DIV_W = pll_cfg_pkg::DIV_W_DEF
) (
    input  logic             FREF,
    input  logic             RESET_N,
    input  logic             en,
    input  logic [DIV_W-1:0] div_ratio,
    output logic             out0,
    output logic             out1
);

    logic [DIV_W-1:0] cnt;       // position in the period
    logic [DIV_W:0]   div_p1;    // div_ratio + 1, one bit wider
    logic [DIV_W-1:0] half;      // ceil(div_ratio / 2)
    logic             last;      // end of period

    assign div_p1 = {1'b0, div_ratio} + 1'b1;
    assign half   = div_p1[DIV_W:1];
    assign last   = (cnt >= div_ratio - 1'b1);  // ratio is 2 or more

    // period counter and out0
    // high for the first half cycles, rounded up for odd ratios
    always_ff @(posedge FREF)
    begin
        if (!RESET_N || !en)
        begin
            cnt  <= '0;
            out0 <= 1'b0;
        end
        else
        begin
            if (last)
                cnt <= '0;
            else
                cnt <= cnt + 1'b1;
            out0 <= (cnt < half);
        end
    end

    // out1 trails out0 by one cycle
    always_ff @(posedge FREF)
    begin
        if (!RESET_N || !en)
            out1 <= 1'b0;
        else
            out1 <= out0;
    end

endmodule

//--- pll_startup_top.sv
/*
 * clock synthesizer start-up sequencer top level
 * registers, sequencer and output dividers on FREF
 */
`timescale 1ns/10ps

module pll_startup_top #(
    parameter int DIV_W = 6
) (
    input  logic                   FREF,
    input  logic                   RESET_N,
    input  logic                   wr_stb,
    input  logic                   rd_stb,
    input  pll_cfg_pkg::cfg_addr_e addr,
    input  logic [7:0]             wdata,
    output logic [7:0]             rd_data,
    output logic                   powerdown_n,
    output logic                   bypass_n,
    output logic                   seq_done,
    output logic                   out0,
    output logic                   out1
);
    import pll_cfg_pkg::*;
    import pll_seq_pkg::*;

    pll_cfg_t  cfg;    // static configuration
    pll_ctrl_t ctrl;   // sequencer controls
    logic      start;  // one cycle start pulse

    pll_cfg_regs #(
        .DIV_W (DIV_W)
    ) u_regs (
        .FREF    (FREF),
        .RESET_N (RESET_N),
        .wr_stb  (wr_stb),
        .rd_stb  (rd_stb),
        .addr    (addr),
        .wdata   (wdata),
        .rd_data (rd_data),
        .cfg     (cfg),
        .start   (start)
    );

    ext_fb_resync u_resync (
        .FREF        (FREF),
        .RESET_N     (RESET_N),
        .start       (start),
        .out0        (out0),          // feedback from the divider bank
        .edge_target (cfg.edge_target),
        .ctrl        (ctrl)
    );

    out_div_bank #(
        .DIV_W (DIV_W)
    ) u_div (
        .FREF      (FREF),
        .RESET_N   (RESET_N),
        .en        (ctrl.out_en),
        .div_ratio (cfg.div_ratio[DIV_W-1:0]),
        .out0      (out0),
        .out1      (out1)
    );

    assign powerdown_n = ctrl.powerdown_n;
    assign bypass_n    = ctrl.bypass_n;
    assign seq_done    = ctrl.seq_done;

endmodule

//--- pll_startup_chk.sv
/*
 * start-up sequencer assertions, bound into ext_fb_resync
 */
`timescale 1ns/10ps

module pll_startup_chk (
    input logic                     FREF,
    input logic                     RESET_N,
    input logic                     start,
    input pll_seq_pkg::seq_state_e  state,
    input pll_seq_pkg::pll_ctrl_t   ctrl
);
    import pll_seq_pkg::*;

    // reset leaves every control low
    a_reset_clear: assert property (@(posedge FREF) !RESET_N |=> ctrl == '0)
        else $error("ctrl not all zero one cycle after reset");

    // done only with the synthesizer fully out of powerdown and bypass
    a_done_live: assert property (@(posedge FREF) disable iff (!RESET_N)
        ctrl.seq_done |-> (ctrl.powerdown_n && ctrl.bypass_n))
        else $error("seq_done high while powerdown_n or bypass_n low");

    // bypass stays released in RUN until a new start
    a_bypass_hold: assert property (@(posedge FREF) disable iff (!RESET_N)
        (state == RUN && ctrl.bypass_n && !start) |=> ctrl.bypass_n)
        else $error("bypass_n fell in RUN without a start");

endmodule

bind ext_fb_resync pll_startup_chk u_chk (
    .FREF    (FREF),
    .RESET_N (RESET_N),
    .start   (start),
    .state   (state),
    .ctrl    (ctrl)
);

//--- tb_pll_startup.sv
/*
 * testbench for the clock synthesizer start-up sequencer
 * file driven register setup, start, done wait and divider output checks
 */
`timescale 1ns/10ps

module tb_pll_startup;
    import pll_cfg_pkg::*;

    localparam int MAX_CASES = 16;

    logic        fref, RESET_N, wr_stb, rd_stb;
    cfg_addr_e   addr;
    logic [7:0]  wdata, rd_data;
    logic        powerdown_n, bypass_n, seq_done, out0, out1;
    logic [7:0]  stim [0:3*MAX_CASES-1];   // div, edges, expected div read-back
    int          num_cases, err_count, check_count, cycles;
    int          cycle_limit = 0;
    int unsigned rnd;

    pll_startup_top #(.DIV_W(6)) UUT (
        .FREF(fref), .RESET_N(RESET_N), .wr_stb(wr_stb), .rd_stb(rd_stb),
        .addr(addr), .wdata(wdata), .rd_data(rd_data), .powerdown_n(powerdown_n),
        .bypass_n(bypass_n), .seq_done(seq_done), .out0(out0), .out1(out1)
    );

    initial
    begin
        fref = 1'b0;
        forever #20 fref = ~fref;  // 40 ns period
    end

    // watchdog, limit set once the stimulus is known
    initial
    begin
        cycles = 0;
        wait (cycle_limit > 0);
        while (cycles < cycle_limit)
        begin
            @(posedge fref);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("sim failed");
        $finish;
    end

    task automatic compare(input string name, input logic [7:0] expected,
                           input logic [7:0] actual);
        check_count++;
        if (actual !== expected)
        begin
            err_count++;
            $display("ERROR at %0t: %s expected %0h got %0h", $time, name, expected, actual);
        end
    endtask

    task automatic write_reg(input cfg_addr_e a, input logic [7:0] d);
        addr   = a;
        wdata  = d;
        wr_stb = 1'b1;
        @(negedge fref);
        wr_stb = 1'b0;  // single cycle strobe
    endtask

    task automatic read_check(input cfg_addr_e a, input logic [7:0] expected,
                              input string name);
        addr   = a;
        rd_stb = 1'b1;
        @(negedge fref);
        rd_stb = 1'b0;
        compare(name, expected, rd_data);  // one cycle after the strobe
    endtask

    // out0 period and duty, out1 one cycle behind
    task automatic check_divider(input int div);
        int   i;
        logic prev;
        prev = out0;
        @(negedge fref);
        while (!(out0 && !prev))
        begin
            prev = out0;
            @(negedge fref);
        end
        for (i = 0; i < 2 * div; i++)
        begin
            compare("out0", 8'((i % div) < (div + 1) / 2), out0);
            compare("out1", 8'(prev), out1);
            prev = out0;
            @(negedge fref);
        end
    endtask

    task automatic run_case(input logic [7:0] div_wr, input logic [7:0] edges,
                            input logic [7:0] exp_div);
        int bound;
        int n;
        bound = (edges + 3) * exp_div + 12;
        write_reg(CFG_DIV, div_wr);
        write_reg(CFG_EDGES, edges);
        read_check(CFG_DIV, exp_div, "rd_data div_ratio");
        read_check(CFG_EDGES, edges, "rd_data edge_target");
        write_reg(CFG_CTRL, 8'h01);
        @(negedge fref);  // start has reached the FSM
        compare("seq_done", 8'h00, seq_done);
        compare("powerdown_n", 8'h00, powerdown_n);
        compare("bypass_n", 8'h00, bypass_n);
        @(negedge fref);  // dividers clear a cycle after out_en drops
        compare("out0", 8'h00, out0);
        compare("out1", 8'h00, out1);
        n = 3;
        while (!seq_done && n < bound)
        begin
            @(negedge fref);
            n++;
        end
        if (!seq_done)
        begin
            err_count++;
            $display("seq_done did not rise within %0d cycles for div %0d edges %0d",
                     bound, exp_div, edges);
        end
        else
        begin
            compare("powerdown_n", 8'h01, powerdown_n);
            compare("bypass_n", 8'h01, bypass_n);
            check_divider(exp_div);
        end
    endtask

    initial
    begin
        rnd = $urandom(80);  // seed once
        {RESET_N, wr_stb, rd_stb, wdata} = '0;
        addr        = CFG_DIV;
        err_count   = 0;
        check_count = 0;
        for (int i = 0; i < 3 * MAX_CASES; i++)
            stim[i] = 8'hff;  // end marker
        $readmemh("pll_startup_stimulus.txt", stim);
        num_cases = 0;
        while (num_cases < MAX_CASES && stim[3*num_cases] !== 8'hff)
            num_cases++;
        // per-case done bounds plus slack for reset, register traffic and checks
        cycle_limit = 200;
        for (int i = 0; i < num_cases; i++)
            cycle_limit += (stim[3*i+1] + 3) * stim[3*i+2] + 12;
        if (num_cases == 0)
        begin
            err_count++;
            $display("no test cases found in the stimulus file");
        end
        repeat (16) @(negedge fref);
        RESET_N = 1'b1;
        @(negedge fref);
        compare("powerdown_n", 8'h00, powerdown_n);
        compare("bypass_n", 8'h00, bypass_n);
        compare("seq_done", 8'h00, seq_done);
        compare("out0", 8'h00, out0);
        compare("out1", 8'h00, out1);
        read_check(CFG_DIV, 8'd4, "rd_data reset div_ratio");
        read_check(CFG_EDGES, 8'd5, "rd_data reset edge_target");
        read_check(CFG_CTRL, 8'd1, "rd_data reset ext_mode");
        for (int i = 0; i < num_cases; i++)
        begin
            repeat ($urandom % 4) @(negedge fref);  // idle gap
            run_case(stim[3*i], stim[3*i+1], stim[3*i+2]);
        end
        $display("cases: %0d  checks: %0d  errors: %0d", num_cases, check_count, err_count);
        if (err_count == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

//--- pll_startup_stimulus.txt
// columns (hex): div_ratio written, edge_target, expected div_ratio read-back
// a written div_ratio of 0 or 1 reads back clamped to 2
03 02 03
00 01 02
07 03 07
01 00 02
0a 04 0a
05 07 05

//--- sim.f
pll_cfg_pkg.sv
pll_seq_pkg.sv
pll_cfg_regs.sv
ext_fb_resync.sv
out_div_bank.sv
pll_startup_top.sv
pll_startup_chk.sv
tb_pll_startup.sv
